// File: game_link.f
hdl/uart_pkg.sv
hdl/game_msg_pkg.sv
hdl/baud_tick_gen.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/msg_decoder.sv
hdl/msg_encoder.sv
hdl/game_link.sv
tb/game_link_tb.sv

// File: hdl/baud_tick_gen.sv
`timescale 1ns/100ps

module baud_tick_gen #(
    parameter int BAUD_DIV = 27
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

    logic [CNT_W-1:0] cnt;

    // Tick is registered, so the first one shows up BAUD_DIV cycles after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == CNT_W'(BAUD_DIV - 1)) begin
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

    // Both UART halves count ticks, so a doubled tick would shorten every bit
    tick_single_cycle: assert property (
        @(posedge clk) disable iff (rst)
        (BAUD_DIV > 1) |-> !(tick && $past(tick))
    );

endmodule

// File: hdl/game_link.sv
`timescale 1ns/100ps

module game_link #(
    parameter int BAUD_DIV = 27
) (
    input  logic clk,
    input  logic rst,
    input  logic multiplayer,
    input  logic rx,
    input  logic send_lose,
    input  logic send_hit,
    input  logic send_ready,
    output logic tx,
    output logic victory,
    output logic opponent_ready,
    output logic opponent_hit
);

    logic       tick;
    logic [7:0] rx_data;
    logic       rx_done_tick;
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;

    // One oversampling tick shared by both directions
    baud_tick_gen #(
        .BAUD_DIV (BAUD_DIV)
    ) u_baud_tick_gen (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    ////////////////////////////////////////////////////
    // Receive side
    ////////////////////////////////////////////////////

    uart_rx u_uart_rx (
        .clk          (clk),
        .rst          (rst),
        .tick         (tick),
        .rx           (rx),
        .rx_data      (rx_data),
        .rx_done_tick (rx_done_tick)
    );

    msg_decoder u_msg_decoder (
        .clk            (clk),
        .rst            (rst),
        .multiplayer    (multiplayer),
        .rx_done_tick   (rx_done_tick),
        .rx_data        (rx_data),
        .victory        (victory),
        .opponent_ready (opponent_ready),
        .opponent_hit   (opponent_hit)
    );

    ////////////////////////////////////////////////////
    // Send side
    ////////////////////////////////////////////////////

    msg_encoder u_msg_encoder (
        .clk        (clk),
        .rst        (rst),
        .send_lose  (send_lose),
        .send_hit   (send_hit),
        .send_ready (send_ready),
        .tx_busy    (tx_busy),
        .tx_start   (tx_start),
        .tx_data    (tx_data)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

// File: hdl/game_msg_pkg.sv
package game_msg_pkg;

    ////////////////////////////////////////////////////
    // One-character game messages between the boards
    ////////////////////////////////////////////////////

    // 'L': the sender has lost, so the receiving side wins
    localparam logic [7:0] MSG_LOSE = 8'h4C;

    // 'H': the sender reports a hit on the receiving side
    localparam logic [7:0] MSG_HIT = 8'h48;

    // 'R': the sender has placed its fleet and is ready
    localparam logic [7:0] MSG_READY = 8'h52;

    // Every code is printable ASCII, so a terminal can stand in for
    // the other board during bring-up

endpackage

// File: hdl/msg_decoder.sv
`timescale 1ns/100ps

module msg_decoder
    import game_msg_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       multiplayer,
    input  logic       rx_done_tick,
    input  logic [7:0] rx_data,
    output logic       victory,
    output logic       opponent_ready,
    output logic       opponent_hit
);

    localparam logic [1:0] ST_IDLE           = 2'b00,
                           ST_VICTORY        = 2'b01,
                           ST_OPPONENT_READY = 2'b10,
                           ST_OPPONENT_HIT   = 2'b11;

    logic [1:0] state, state_nxt;
    logic       victory_nxt;
    logic       opponent_ready_nxt;
    logic       opponent_hit_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= ST_IDLE;
            victory        <= 1'b0;
            opponent_ready <= 1'b0;
            opponent_hit   <= 1'b0;
        end else begin
            state          <= state_nxt;
            victory        <= victory_nxt;
            opponent_ready <= opponent_ready_nxt;
            opponent_hit   <= opponent_hit_nxt;
        end
    end

    always_comb begin
        state_nxt          = ST_IDLE;
        victory_nxt        = 1'b0;
        opponent_ready_nxt = 1'b0;
        opponent_hit_nxt   = 1'b0;
        case (state)
            ST_IDLE: begin
                // Characters from the other board only matter in a two-player game
                if (multiplayer && rx_done_tick) begin
                    if (rx_data == MSG_LOSE)       state_nxt = ST_VICTORY;
                    else if (rx_data == MSG_HIT)   state_nxt = ST_OPPONENT_HIT;
                    else if (rx_data == MSG_READY) state_nxt = ST_OPPONENT_READY;
                end
            end
            ST_VICTORY:        victory_nxt        = 1'b1;
            ST_OPPONENT_READY: opponent_ready_nxt = 1'b1;
            ST_OPPONENT_HIT:   opponent_hit_nxt   = 1'b1;
            default:           state_nxt          = ST_IDLE;
        endcase
    end

    events_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({victory, opponent_ready, opponent_hit})
    );

endmodule

// File: hdl/msg_encoder.sv
`timescale 1ns/100ps

module msg_encoder
    import game_msg_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       send_lose,
    input  logic       send_hit,
    input  logic       send_ready,
    input  logic       tx_busy,
    output logic       tx_start,
    output logic [7:0] tx_data
);

    logic pend_lose;
    logic pend_hit;
    logic pend_ready;
    logic can_send;
    logic sel_lose;
    logic sel_hit;
    logic sel_ready;

    // Busy only rises the cycle after a start, so skip the cycle right after one
    assign can_send = !tx_busy && !tx_start;

    // Fixed priority: losing ends the game, so it goes out first
    assign sel_lose  = can_send && pend_lose;
    assign sel_hit   = can_send && !pend_lose && pend_hit;
    assign sel_ready = can_send && !pend_lose && !pend_hit && pend_ready;

    ////////////////////////////////////////////////////
    // Pending requests
    ////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_lose  <= 1'b0;
            pend_hit   <= 1'b0;
            pend_ready <= 1'b0;
            tx_start   <= 1'b0;
        end else begin
            // A new request wins over the clear, repeats just merge
            pend_lose  <= send_lose  || (pend_lose  && !sel_lose);
            pend_hit   <= send_hit   || (pend_hit   && !sel_hit);
            pend_ready <= send_ready || (pend_ready && !sel_ready);
            tx_start   <= sel_lose || sel_hit || sel_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_lose) begin
            tx_data <= MSG_LOSE;
        end else if (sel_hit) begin
            tx_data <= MSG_HIT;
        end else if (sel_ready) begin
            tx_data <= MSG_READY;
        end
    end

endmodule

// File: hdl/uart_pkg.sv
package uart_pkg;

    ////////////////////////////////////////////////////
    // Frame format for the 8N1 link
    ////////////////////////////////////////////////////

    // Ticks of the shared oversampling clock per bit period
    localparam int OVERSAMPLE = 16;

    // Payload bits in one frame, sent LSB first
    localparam int DATA_BITS = 8;

    // Width of the counters that run through one bit period
    localparam int TICK_CNT_W = $clog2(OVERSAMPLE);

    // Width of the counters that run through the payload bits
    localparam int BIT_CNT_W = $clog2(DATA_BITS);

endpackage

// File: hdl/uart_rx.sv
`timescale 1ns/100ps

module uart_rx
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_done_tick
);

    localparam logic [1:0] ST_IDLE  = 2'd0,
                           ST_START = 2'd1,
                           ST_DATA  = 2'd2,
                           ST_STOP  = 2'd3;

    // Middle of the start bit, then one full bit period between samples
    localparam logic [TICK_CNT_W-1:0] START_SAMPLE = TICK_CNT_W'(OVERSAMPLE / 2 - 1);
    localparam logic [TICK_CNT_W-1:0] BIT_SAMPLE   = TICK_CNT_W'(OVERSAMPLE - 1);

    logic [1:0]            state;
    logic [1:0]            rx_meta;
    logic                  rx_sync;
    logic [TICK_CNT_W-1:0] tick_cnt;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [DATA_BITS-1:0]  shreg;

    // The line comes from another board, so bring it into this clock domain first
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 2'b11;
        end else begin
            rx_meta <= {rx_meta[0], rx};
        end
    end

    assign rx_sync = rx_meta[1];

    ////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= ST_IDLE;
            tick_cnt     <= '0;
            bit_cnt      <= '0;
            rx_done_tick <= 1'b0;
        end else begin
            rx_done_tick <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (!rx_sync) begin
                        state    <= ST_START;
                        tick_cnt <= '0;
                    end
                end
                ST_START: begin
                    if (tick) begin
                        if (tick_cnt == START_SAMPLE) begin
                            // A glitch shorter than half a bit is not a start bit
                            state    <= rx_sync ? ST_IDLE : ST_DATA;
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                ST_DATA: begin
                    if (tick) begin
                        if (tick_cnt == BIT_SAMPLE) begin
                            tick_cnt <= '0;
                            if (bit_cnt == BIT_CNT_W'(DATA_BITS - 1)) begin
                                state <= ST_STOP;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                ST_STOP: begin
                    if (tick) begin
                        if (tick_cnt == BIT_SAMPLE) begin
                            state        <= ST_IDLE;
                            rx_done_tick <= rx_sync;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Payload path, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == ST_DATA && tick && tick_cnt == BIT_SAMPLE) begin
            shreg <= {rx_sync, shreg[DATA_BITS-1:1]};
        end
        if (state == ST_STOP && tick && tick_cnt == BIT_SAMPLE && rx_sync) begin
            rx_data <= shreg;
        end
    end

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/100ps

module uart_tx
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx,
    output logic       tx_busy
);

    localparam logic [1:0] ST_IDLE  = 2'd0,
                           ST_START = 2'd1,
                           ST_DATA  = 2'd2,
                           ST_STOP  = 2'd3;

    localparam logic [TICK_CNT_W-1:0] LAST_TICK = TICK_CNT_W'(OVERSAMPLE - 1);

    logic [1:0]            state;
    logic [TICK_CNT_W-1:0] tick_cnt;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [DATA_BITS-1:0]  shreg;
    logic                  bit_end;

    // Each bit is driven on tick 0 of its period and ends after tick 15
    assign bit_end = tick && (tick_cnt == LAST_TICK);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;
        end else begin
            if (state != ST_IDLE && tick) begin
                tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (tx_start) begin
                        state    <= ST_START;
                        tick_cnt <= '0;
                    end
                end
                ST_START: begin
                    if (tick && tick_cnt == '0) tx <= 1'b0;
                    if (bit_end) begin
                        state   <= ST_DATA;
                        bit_cnt <= '0;
                    end
                end
                ST_DATA: begin
                    if (tick && tick_cnt == '0) tx <= shreg[0];
                    if (bit_end) begin
                        if (bit_cnt == BIT_CNT_W'(DATA_BITS - 1)) state <= ST_STOP;
                        else bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                ST_STOP: begin
                    if (tick && tick_cnt == '0) tx <= 1'b1;
                    if (bit_end) state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && tx_start) begin
            shreg <= tx_data;
        end else if (state == ST_DATA && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

    assign tx_busy = (state != ST_IDLE);

    // The encoder must wait out the whole frame before the next start
    no_start_while_busy: assert property (
        @(posedge clk) disable iff (rst) tx_start |-> !tx_busy
    );

endmodule

// File: tb/game_link_tb.sv
`timescale 1ns/100ps

module game_link_tb
    import uart_pkg::*;
    import game_msg_pkg::*;
();

    localparam int BAUD_DIV        = 2;
    localparam int CLK_PERIOD      = 10;
    localparam int BIT_CYCLES      = OVERSAMPLE * BAUD_DIV;
    localparam int N_RX_FRAMES     = 40;
    localparam int N_BURSTS        = 12;
    localparam int RX_GAP_BITS     = 2;
    localparam int RX_BAD_GAP_BITS = 12;
    localparam int TX_GAP_BITS     = 3;
    // A burst sends at most four characters
    // Each frame is 10 bits plus idle time
    localparam longint TIMEOUT_NS  = longint'(N_RX_FRAMES + 4 * N_BURSTS)
                                     * (10 + RX_BAD_GAP_BITS) * BIT_CYCLES * CLK_PERIOD
                                     + 20000;

    logic clk;
    logic rst;
    logic multiplayer;
    logic rx;
    logic send_lose;
    logic send_hit;
    logic send_ready;
    logic tx;
    logic victory;
    logic opponent_ready;
    logic opponent_hit;

    // Characters still owed by the DUT, oldest first
    logic [7:0] ev_q[$];
    logic [7:0] tx_q[$];

    game_link #(
        .BAUD_DIV (BAUD_DIV)
    ) dut0 (
        .clk            (clk),
        .rst            (rst),
        .multiplayer    (multiplayer),
        .rx             (rx),
        .send_lose      (send_lose),
        .send_hit       (send_hit),
        .send_ready     (send_ready),
        .tx             (tx),
        .victory        (victory),
        .opponent_ready (opponent_ready),
        .opponent_hit   (opponent_hit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Error reporting
    //////////////////////////////////////////////////

    task automatic fail_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test_name, input logic [7:0] exp,
                                   input logic [7:0] act);
        $display("Mismatch in %s: expected 8'h%h, actual 8'h%h", test_name, exp, act);
        fail_run();
    endtask

    task automatic report_failure(input string what);
        $display("Error: %s", what);
        fail_run();
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    function automatic logic [7:0] msg_code(input int kind);
        case (kind)
            0:       return MSG_LOSE;
            1:       return MSG_HIT;
            default: return MSG_READY;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Receive direction
    //////////////////////////////////////////////////

    // Called right after a falling clock edge
    task automatic drive_rx_frame(input logic [7:0] data, input logic stop_bit);
        int i;
        rx = 1'b0;
        wait_cycles(BIT_CYCLES);
        for (i = 0; i < DATA_BITS; i++) begin
            rx = data[i];
            wait_cycles(BIT_CYCLES);
        end
        rx = stop_bit;
        wait_cycles(BIT_CYCLES);
        rx = 1'b1;
    endtask

    task automatic run_rx_frame();
        logic [7:0] data;
        logic       stop_ok;
        logic       mp;
        int         pick;
        pick = $urandom_range(0, 4);
        data = (pick < 3) ? msg_code(pick) : 8'($urandom);
        stop_ok = ($urandom_range(0, 5) != 0);
        mp = ($urandom_range(0, 3) != 0);
        @(negedge clk);
        multiplayer = mp;
        if (mp && stop_ok && (data == MSG_LOSE || data == MSG_HIT || data == MSG_READY)) begin
            ev_q.push_back(data);
        end
        drive_rx_frame(data, stop_ok);
        // A low stop bit can look like a new start bit, so let that false frame run out
        wait_cycles((stop_ok ? RX_GAP_BITS : RX_BAD_GAP_BITS) * BIT_CYCLES);
        assert (ev_q.size() == 0)
            else report_failure("a received game message produced no event pulse");
    endtask

    //////////////////////////////////////////////////
    // Send direction
    //////////////////////////////////////////////////

    task automatic pulse_request(input int kind);
        @(negedge clk);
        send_lose  = (kind == 0);
        send_hit   = (kind == 1);
        send_ready = (kind == 2);
        @(negedge clk);
        send_lose  = 1'b0;
        send_hit   = 1'b0;
        send_ready = 1'b0;
    endtask

    // One request on an idle link, then more while its frame is still on the wire
    task automatic run_send_burst();
        logic [2:0] pend;
        int         n_req;
        int         kind;
        pend = '0;
        kind = $urandom_range(0, 2);
        pulse_request(kind);
        tx_q.push_back(msg_code(kind));
        wait_cycles(20);
        n_req = $urandom_range(0, 5);
        repeat (n_req) begin
            kind = $urandom_range(0, 2);
            pulse_request(kind);
            pend[kind] = 1'b1;
            wait_cycles($urandom_range(1, 30));
        end
        for (kind = 0; kind < 3; kind++) begin
            if (pend[kind]) tx_q.push_back(msg_code(kind));
        end
        while (tx_q.size() != 0) @(negedge clk);
        wait_cycles(TX_GAP_BITS * BIT_CYCLES);
    endtask

    //////////////////////////////////////////////////
    // Monitors
    //////////////////////////////////////////////////

    initial begin : event_monitor
        logic [7:0] got;
        logic [7:0] exp;
        @(negedge rst);
        forever begin
            @(negedge clk);
            assert ($onehot0({victory, opponent_hit, opponent_ready}))
                else report_failure("more than one event output is high in the same cycle");
            if (victory || opponent_hit || opponent_ready) begin
                got = victory ? MSG_LOSE : (opponent_hit ? MSG_HIT : MSG_READY);
                assert (ev_q.size() != 0)
                    else report_failure("an event pulse appeared that no frame called for");
                exp = ev_q.pop_front();
                assert (got == exp) else report_mismatch("rx_event", exp, got);
            end
        end
    end

    initial begin : tx_monitor
        logic [7:0] got;
        logic [7:0] exp;
        @(negedge rst);
        forever begin
            @(negedge clk);
            if (!tx) begin
                // Sample every bit near its middle
                wait_cycles(BIT_CYCLES / 2 - 1);
                assert (!tx) else report_failure("the tx start bit is shorter than half a bit");
                repeat (DATA_BITS) begin
                    wait_cycles(BIT_CYCLES);
                    got = {tx, got[7:1]};
                end
                wait_cycles(BIT_CYCLES);
                assert (tx) else report_failure("the tx stop bit is low");
                assert (tx_q.size() != 0)
                    else report_failure("tx sent a character that no request asked for");
                exp = tx_q.pop_front();
                assert (got == exp) else report_mismatch("tx_char", exp, got);
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        fail_run();
    end

    initial begin : stimulus
        rst         = 1'b1;
        multiplayer = 1'b0;
        rx          = 1'b1;
        send_lose   = 1'b0;
        send_hit    = 1'b0;
        send_ready  = 1'b0;
        void'($urandom(32'h2f30));
        repeat (10) @(negedge clk);
        assert (!victory && !opponent_hit && !opponent_ready && tx)
            else report_failure("outputs are not idle after reset");
        rst = 1'b0;
        repeat (N_RX_FRAMES) run_rx_frame();
        repeat (N_BURSTS) run_send_burst();
        wait_cycles(4 * BIT_CYCLES);
        assert (ev_q.size() == 0 && tx_q.size() == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            report_failure("expected responses are still outstanding at the end");
        end
    end

endmodule
